// ==== compile.f ====
+incdir+.
riscv_pkg.sv
segre_pkg.sv
segre_register_file.sv
segre_if_stage.sv
segre_id_stage.sv
segre_ex_stage.sv
segre_mmu.sv
segre_core.sv
tb_segre_core.sv

// ==== Makefile ====
SRCS = riscv_pkg.sv segre_pkg.sv segre_register_file.sv segre_if_stage.sv \
       segre_id_stage.sv segre_ex_stage.sv segre_mmu.sv segre_core.sv \
       tb_segre_core.sv tb_program.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_segre_core: compile.f $(SRCS)
	verilator --binary -f compile.f --top-module tb_segre_core -Mdir obj_dir

run: obj_dir/Vtb_segre_core
	./obj_dir/Vtb_segre_core | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Program image at the boot address, data words and the store sequence it must produce
task automatic load_image();
    int base;
    base = int'(BOOT_ADDR >> 2);
    for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = word_t'(i) << 8;
    end
    // ALU chain with back-to-back dependencies
    mem[base + 0]  = 32'h00500093; // addi x1, x0, 5
    mem[base + 1]  = 32'h12345137; // lui  x2, 0x12345
    mem[base + 2]  = 32'h002081B3; // add  x3, x1, x2
    mem[base + 3]  = 32'h40118233; // sub  x4, x3, x1
    mem[base + 4]  = 32'h0011F2B3; // and  x5, x3, x1
    mem[base + 5]  = 32'h00526333; // or   x6, x4, x5
    mem[base + 6]  = 32'h002343B3; // xor  x7, x6, x2
    mem[base + 7]  = 32'hFFF00493; // addi x9, x0, -1
    mem[base + 8]  = 32'h0074A433; // slt  x8, x9, x7
    mem[base + 9]  = 32'h20402023; // sw   x4, 0x200(x0)
    mem[base + 10] = 32'h20702223; // sw   x7, 0x204(x0)
    mem[base + 11] = 32'h20802423; // sw   x8, 0x208(x0)
    // Loads, the add right behind them is a load-use case
    mem[base + 12] = 32'h10002503; // lw   x10, 0x100(x0)
    mem[base + 13] = 32'h10402583; // lw   x11, 0x104(x0)
    mem[base + 14] = 32'h00B50633; // add  x12, x10, x11
    mem[base + 15] = 32'h20C02623; // sw   x12, 0x20c(x0)
    // Taken beq and jal over poison stores
    mem[base + 16] = 32'h00708663; // beq  x1, x7, +12
    mem[base + 17] = 32'h20902823; // sw   x9, 0x210(x0)
    mem[base + 18] = 32'h20902823; // sw   x9, 0x210(x0)
    mem[base + 19] = 32'h00C0006F; // jal  x0, +12
    mem[base + 20] = 32'h20902823; // sw   x9, 0x210(x0)
    mem[base + 21] = 32'h20902823; // sw   x9, 0x210(x0)
    // Count to five with bne
    mem[base + 22] = 32'h00000693; // addi x13, x0, 0
    mem[base + 23] = 32'h00168693; // addi x13, x13, 1
    mem[base + 24] = 32'hFE169EE3; // bne  x13, x1, -4
    mem[base + 25] = 32'h20D02823; // sw   x13, 0x210(x0)
    mem[base + 26] = 32'h0000006F; // jal  x0, 0
    // Preloaded data at 0x100
    mem[64] = 32'h00001111;
    mem[65] = 32'h00002222;
    exp_addr = {32'h200, 32'h204, 32'h208, 32'h20C, 32'h210};
    exp_data = {32'h12345000, 32'h5, 32'h1, 32'h3333, 32'h5};
endtask

`endif

// ==== tb_segre_core.sv ====
`timescale 1ns/1ns

module tb_segre_core;

    import riscv_pkg::*;
    import segre_pkg::*;

    localparam addr_t BOOT_ADDR      = 32'h80;
    localparam int    MEM_WORDS      = 256;
    localparam int    TIMEOUT_CYCLES = 20000;
    localparam word_t POISON         = 32'hFFFF_FFFF;

    logic  clk_i;
    logic  rst_n_i;
    logic  mm_data_rdy_i;
    word_t mm_rd_data_i;
    word_t mm_wr_data_o;
    addr_t mm_addr_o;
    addr_t mm_wr_addr_o;
    logic  mm_rd_o;
    logic  mm_wr_o;

    word_t mem [MEM_WORDS];
    addr_t exp_addr [$];
    word_t exp_data [$];
    int    seed = 59073;
    int    errors = 0;
    int    checks = 0;
    int    cycles;
    bit    first_req_seen = 0;
    bit    req_open = 0;
    bit    reset_seen;
    int    wait_left;
    addr_t held_addr;
    word_t held_data;
    logic  held_wr;

    `include "tb_program.svh"

    segre_core #(
        .BOOT_ADDR (BOOT_ADDR)
    ) segre_core_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_wr_data_o  (mm_wr_data_o),
        .mm_addr_o     (mm_addr_o),
        .mm_wr_addr_o  (mm_wr_addr_o),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    task automatic check_value(string name, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(bit cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("At %0t ns: %s", $time, what);
        end
    endtask

    task automatic record_store(addr_t addr, word_t data);
        check_true(data !== POISON, "poison value stored, a skipped store was executed");
        if (exp_addr.size() == 0) begin
            check_true(1'b0, "store beyond the end of the expected list");
        end else begin
            check_value("mm_wr_addr_o", addr, exp_addr.pop_front());
            check_value("mm_wr_data_o", data, exp_data.pop_front());
        end
    endtask

    // Memory model, answers after 0 to 4 extra cycles
    task automatic serve_memory(bit in_reset);
        mm_data_rdy_i = 1'b0;
        if (in_reset) begin
            check_true(!mm_rd_o && !mm_wr_o, "memory request during reset");
            return;
        end
        check_true(!(mm_rd_o && mm_wr_o), "read and write requested together");
        if (!first_req_seen) begin
            check_true(!mm_wr_o, "write before the first fetch");
            if (mm_rd_o) begin
                first_req_seen = 1'b1;
                check_value("mm_addr_o", mm_addr_o, BOOT_ADDR);
            end
        end
        if (mm_rd_o || mm_wr_o) begin
            if (!req_open) begin
                req_open  = 1'b1;
                wait_left = $unsigned($random(seed)) % 5;
                held_wr   = mm_wr_o;
                held_addr = mm_wr_o ? mm_wr_addr_o : mm_addr_o;
                held_data = mm_wr_data_o;
            end else begin
                check_true(mm_wr_o === held_wr, "request type changed before ready");
                if (held_wr) begin
                    check_value("mm_wr_addr_o", mm_wr_addr_o, held_addr);
                    check_value("mm_wr_data_o", mm_wr_data_o, held_data);
                end else begin
                    check_value("mm_addr_o", mm_addr_o, held_addr);
                end
            end
            check_true(held_addr[31:10] == '0, "access outside the memory model");
            if (wait_left == 0) begin
                mm_data_rdy_i = 1'b1;
                req_open      = 1'b0;
                if (held_wr) begin
                    mem[held_addr[9:2]] = mm_wr_data_o;
                    record_store(mm_wr_addr_o, mm_wr_data_o);
                end else begin
                    mm_rd_data_i = mem[held_addr[9:2]];
                end
            end else begin
                wait_left--;
            end
        end
    endtask

    // Reset state taken at the edge, before the model acts
    always @(posedge clk_i) begin
        reset_seen = !rst_n_i;
        #5;
        serve_memory(reset_seen);
    end

    initial begin
        rst_n_i       = 1'b0;
        mm_data_rdy_i = 1'b0;
        mm_rd_data_i  = '0;
        load_image();
        repeat (16) @(posedge clk_i);
        #5 rst_n_i = 1'b1;

        // Run until every expected store has been seen
        cycles = 0;
        while (exp_addr.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_addr.size() != 0) begin
            check_true(1'b0, "timeout waiting for the expected stores");
        end else begin
            // Keep the self loop running to catch stray stores
            repeat (50) @(posedge clk_i);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_segre_core

// ==== segre_core.sv ====
`timescale 1ns/1ns

module segre_core #(
    parameter segre_pkg::addr_t BOOT_ADDR = '0
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    // Main memory
    input  logic             mm_data_rdy_i,
    input  riscv_pkg::word_t mm_rd_data_i,
    output riscv_pkg::word_t mm_wr_data_o,
    output segre_pkg::addr_t mm_addr_o,
    output segre_pkg::addr_t mm_wr_addr_o,
    output logic             mm_rd_o,
    output logic             mm_wr_o
);

    import riscv_pkg::*;
    import segre_pkg::*;

    core_id_t       core_id;
    core_pipeline_t core_pipeline;
    rf_wdata_t      rf_wdata;
    mem_req_t       ic_req;
    mem_req_t       dc_req;
    mem_rsp_t       ic_rsp;
    mem_rsp_t       dc_rsp;
    reg_addr_t      rf_raddr_a;
    reg_addr_t      rf_raddr_b;
    word_t          rf_data_a;
    word_t          rf_data_b;
    logic           id_stall;
    logic           ex_busy;
    logic           redirect;
    addr_t          new_pc;

    segre_if_stage #(
        .BOOT_ADDR (BOOT_ADDR)
    ) if_stage (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (id_stall),
        .redirect_i (redirect),
        .new_pc_i   (new_pc),
        .mem_rsp_i  (ic_rsp),
        .mem_req_o  (ic_req),
        .core_id_o  (core_id)
    );

    segre_id_stage id_stage (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .core_id_i       (core_id),
        .ex_busy_i       (ex_busy),
        .redirect_i      (redirect),
        .rf_raddr_a_o    (rf_raddr_a),
        .rf_raddr_b_o    (rf_raddr_b),
        .rf_data_a_i     (rf_data_a),
        .rf_data_b_i     (rf_data_b),
        .bypass_i        (rf_wdata),
        .stall_o         (id_stall),
        .core_pipeline_o (core_pipeline)
    );

    segre_ex_stage ex_stage (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .core_pipeline_i (core_pipeline),
        .mem_rsp_i       (dc_rsp),
        .mem_req_o       (dc_req),
        .busy_o          (ex_busy),
        .rf_wdata_o      (rf_wdata),
        .redirect_o      (redirect),
        .new_pc_o        (new_pc)
    );

    segre_register_file segre_rf (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .data_a_o  (rf_data_a),
        .data_b_o  (rf_data_b),
        .wdata_i   (rf_wdata)
    );

    segre_mmu mmu (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ic_req_i      (ic_req),
        .dc_req_i      (dc_req),
        .ic_rsp_o      (ic_rsp),
        .dc_rsp_o      (dc_rsp),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_wr_data_o  (mm_wr_data_o),
        .mm_addr_o     (mm_addr_o),
        .mm_wr_addr_o  (mm_wr_addr_o),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o)
    );

endmodule : segre_core

// ==== segre_mmu.sv ====
`timescale 1ns/1ns

module segre_mmu (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  segre_pkg::mem_req_t ic_req_i,
    input  segre_pkg::mem_req_t dc_req_i,
    output segre_pkg::mem_rsp_t ic_rsp_o,
    output segre_pkg::mem_rsp_t dc_rsp_o,
    input  logic                mm_data_rdy_i,
    input  riscv_pkg::word_t    mm_rd_data_i,
    output riscv_pkg::word_t    mm_wr_data_o,
    output segre_pkg::addr_t    mm_addr_o,
    output segre_pkg::addr_t    mm_wr_addr_o,
    output logic                mm_rd_o,
    output logic                mm_wr_o
);

    import riscv_pkg::*;
    import segre_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        IFETCH,
        DREAD,
        DWRITE
    } mmu_state_e;

    mmu_state_e state_q;
    mmu_state_e state_d;
    addr_t      addr_q;
    word_t      wdata_q;
    logic       dc_grant;

    assign dc_grant = dc_req_i.rd || dc_req_i.wr;

    // Data side has priority, grants only from idle
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (dc_req_i.wr) begin
                    state_d = DWRITE;
                end else if (dc_req_i.rd) begin
                    state_d = DREAD;
                end else if (ic_req_i.rd) begin
                    state_d = IFETCH;
                end
            end
            default: begin
                if (mm_data_rdy_i) begin
                    state_d = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            addr_q  <= dc_grant ? dc_req_i.addr : ic_req_i.addr;
            wdata_q <= dc_req_i.data;
        end
    end

    assign mm_rd_o      = (state_q == IFETCH) || (state_q == DREAD);
    assign mm_wr_o      = (state_q == DWRITE);
    assign mm_addr_o    = addr_q;
    assign mm_wr_addr_o = addr_q;
    assign mm_wr_data_o = wdata_q;

    // Ready and data only reach the side that owns the port
    assign ic_rsp_o.rdy  = (state_q == IFETCH) && mm_data_rdy_i;
    assign ic_rsp_o.data = (state_q == IFETCH) ? mm_rd_data_i : '0;
    assign dc_rsp_o.rdy  = ((state_q == DREAD) || (state_q == DWRITE)) && mm_data_rdy_i;
    assign dc_rsp_o.data = (state_q == DREAD) ? mm_rd_data_i : '0;

endmodule : segre_mmu

// ==== segre_ex_stage.sv ====
`timescale 1ns/1ns

module segre_ex_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  segre_pkg::core_pipeline_t core_pipeline_i,
    input  segre_pkg::mem_rsp_t       mem_rsp_i,
    output segre_pkg::mem_req_t       mem_req_o,
    output logic                      busy_o,
    output segre_pkg::rf_wdata_t      rf_wdata_o,
    output logic                      redirect_o,
    output segre_pkg::addr_t          new_pc_o
);

    import riscv_pkg::*;
    import segre_pkg::*;

    word_t    alu_res;
    logic     is_mem;
    logic     br_eq;
    mem_req_t req_q;

    always_comb begin
        case (core_pipeline_i.alu_op)
            ADD:     alu_res = core_pipeline_i.op_a + core_pipeline_i.op_b;
            SUB:     alu_res = core_pipeline_i.op_a - core_pipeline_i.op_b;
            AND:     alu_res = core_pipeline_i.op_a & core_pipeline_i.op_b;
            OR:      alu_res = core_pipeline_i.op_a | core_pipeline_i.op_b;
            XOR:     alu_res = core_pipeline_i.op_a ^ core_pipeline_i.op_b;
            SLT:     alu_res = {31'b0, $signed(core_pipeline_i.op_a) <
                                       $signed(core_pipeline_i.op_b)};
            PASS_B:  alu_res = core_pipeline_i.op_b;
            default: alu_res = '0;
        endcase
    end

    // Branch resolution
    assign br_eq      = (core_pipeline_i.op_a == core_pipeline_i.op_b);
    assign redirect_o = core_pipeline_i.valid &&
                        (core_pipeline_i.is_jal ||
                         (core_pipeline_i.is_branch && (br_eq != core_pipeline_i.branch_ne)));
    assign new_pc_o   = core_pipeline_i.br_target;

    assign is_mem = core_pipeline_i.valid &&
                    (core_pipeline_i.memop_rd || core_pipeline_i.memop_wr);
    assign busy_o = is_mem && !mem_rsp_i.rdy;

    // Loads write on their ready cycle, ALU results right away
    assign rf_wdata_o.we    = core_pipeline_i.valid && core_pipeline_i.rf_we &&
                              (!core_pipeline_i.memop_rd || mem_rsp_i.rdy);
    assign rf_wdata_o.waddr = core_pipeline_i.rf_waddr;
    assign rf_wdata_o.data  = core_pipeline_i.memop_rd ? mem_rsp_i.data : alu_res;

    assign mem_req_o = req_q;

    // Request is issued once per memop and held until ready
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q <= '0;
        end else if (mem_rsp_i.rdy) begin
            req_q <= '0;
        end else if (is_mem && !req_q.rd && !req_q.wr) begin
            req_q <= '{rd:   core_pipeline_i.memop_rd,
                       wr:   core_pipeline_i.memop_wr,
                       addr: alu_res,
                       data: core_pipeline_i.store_data};
        end
    end

endmodule : segre_ex_stage

// ==== segre_id_stage.sv ====
`timescale 1ns/1ns

module segre_id_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  segre_pkg::core_id_t       core_id_i,
    input  logic                      ex_busy_i,
    input  logic                      redirect_i,
    output riscv_pkg::reg_addr_t      rf_raddr_a_o,
    output riscv_pkg::reg_addr_t      rf_raddr_b_o,
    input  riscv_pkg::word_t          rf_data_a_i,
    input  riscv_pkg::word_t          rf_data_b_i,
    input  segre_pkg::rf_wdata_t      bypass_i,
    output logic                      stall_o,
    output segre_pkg::core_pipeline_t core_pipeline_o
);

    import riscv_pkg::*;
    import segre_pkg::*;

    word_t               instr;
    opcode_e             opcode;
    reg_addr_t           rs1;
    reg_addr_t           rs2;
    reg_addr_t           rd;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    word_t               imm_i;
    word_t               imm_s;
    word_t               imm_b;
    word_t               imm_u;
    word_t               imm_j;
    word_t               src_a;
    word_t               src_b;
    core_pipeline_t      dec;
    core_pipeline_t      pipe_q;

    assign instr  = core_id_i.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Operand read, with the EX write-back forwarded
    assign rf_raddr_a_o = rs1;
    assign rf_raddr_b_o = rs2;
    assign src_a = (bypass_i.we && bypass_i.waddr == rs1 && rs1 != '0) ?
                   bypass_i.data : rf_data_a_i;
    assign src_b = (bypass_i.we && bypass_i.waddr == rs2 && rs2 != '0) ?
                   bypass_i.data : rf_data_b_i;

    always_comb begin
        dec            = '0;
        dec.valid      = core_id_i.valid;
        dec.alu_op     = ADD;
        dec.op_a       = src_a;
        dec.op_b       = src_b;
        dec.store_data = src_b;
        dec.rf_waddr   = rd;
        case (opcode)
            OP: begin
                dec.rf_we  = (rd != '0);
                case (funct3)
                    F3_ADD_SUB: dec.alu_op = (funct7 == F7_SUB) ? SUB : ADD;
                    F3_SLT:     dec.alu_op = SLT;
                    F3_XOR:     dec.alu_op = XOR;
                    F3_OR:      dec.alu_op = OR;
                    F3_AND:     dec.alu_op = AND;
                    default:    dec.rf_we  = 1'b0;
                endcase
            end
            OP_IMM: begin
                dec.op_b  = imm_i;
                dec.rf_we = (funct3 == F3_ADD_SUB) && (rd != '0);
            end
            LUI: begin
                dec.alu_op = PASS_B;
                dec.op_b   = imm_u;
                dec.rf_we  = (rd != '0);
            end
            LOAD: begin
                dec.op_b     = imm_i;
                dec.memop_rd = (funct3 == F3_WORD);
                dec.rf_we    = dec.memop_rd && (rd != '0);
            end
            STORE: begin
                dec.op_b     = imm_s;
                dec.memop_wr = (funct3 == F3_WORD);
            end
            BRANCH: begin
                dec.is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                dec.branch_ne = (funct3 == F3_BNE);
                dec.br_target = core_id_i.pc + imm_b;
            end
            JAL: begin
                dec.alu_op    = PASS_B;
                dec.op_b      = core_id_i.pc + 32'd4;
                dec.rf_we     = (rd != '0);
                dec.is_jal    = 1'b1;
                dec.br_target = core_id_i.pc + imm_j;
            end
            default: ;
        endcase
    end

    // Busy also holds back a load-use pair until the data is on the bypass
    assign stall_o         = ex_busy_i;
    assign core_pipeline_o = pipe_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pipe_q <= '0;
        end else if (redirect_i) begin
            pipe_q <= '0;
        end else if (!ex_busy_i) begin
            pipe_q <= dec;
        end
    end

endmodule : segre_id_stage

// ==== segre_if_stage.sv ====
`timescale 1ns/1ns

module segre_if_stage #(
    parameter segre_pkg::addr_t BOOT_ADDR = '0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  logic                 redirect_i,
    input  segre_pkg::addr_t     new_pc_i,
    input  segre_pkg::mem_rsp_t  mem_rsp_i,
    output segre_pkg::mem_req_t  mem_req_o,
    output segre_pkg::core_id_t  core_id_o
);

    import riscv_pkg::*;
    import segre_pkg::*;

    addr_t pc_q;
    logic  discard_q;
    logic  id_valid_q;
    word_t id_instr_q;
    addr_t id_pc_q;
    logic  fetch_req;

    // Fetch when the IF/ID register is empty or handed over this cycle
    assign fetch_req = !id_valid_q || !stall_i;

    assign mem_req_o = '{rd: fetch_req, wr: 1'b0, addr: pc_q, data: '0};
    assign core_id_o = '{valid: id_valid_q, instr: id_instr_q, pc: id_pc_q};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= BOOT_ADDR;
            discard_q  <= 1'b0;
            id_valid_q <= 1'b0;
        end else if (redirect_i) begin
            pc_q       <= new_pc_i;
            id_valid_q <= 1'b0;
            // A fetch granted for the old pc still has to drain
            discard_q  <= fetch_req && !mem_rsp_i.rdy;
        end else if (mem_rsp_i.rdy) begin
            if (discard_q) begin
                discard_q <= 1'b0;
            end else begin
                id_valid_q <= 1'b1;
                pc_q       <= pc_q + 32'd4;
            end
        end else if (!stall_i) begin
            id_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_rsp_i.rdy && !discard_q) begin
            id_instr_q <= mem_rsp_i.data;
            id_pc_q    <= pc_q;
        end
    end

endmodule : segre_if_stage

// ==== segre_register_file.sv ====
`timescale 1ns/1ns

module segre_register_file (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  riscv_pkg::reg_addr_t raddr_a_i,
    input  riscv_pkg::reg_addr_t raddr_b_i,
    output riscv_pkg::word_t     data_a_o,
    output riscv_pkg::word_t     data_b_o,
    input  segre_pkg::rf_wdata_t wdata_i
);

    import riscv_pkg::*;

    word_t regs_q [NUM_REGS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wdata_i.we && wdata_i.waddr != '0) begin
            regs_q[wdata_i.waddr] <= wdata_i.data;
        end
    end

    // x0 is hardwired
    assign data_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign data_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule : segre_register_file

// ==== segre_pkg.sv ====
package segre_pkg;

    typedef logic [31:0] addr_t;

    // IF/ID register contents
    typedef struct packed {
        logic             valid;
        riscv_pkg::word_t instr;
        addr_t            pc;
    } core_id_t;

    // Decoded bundle handed to execute
    typedef struct packed {
        logic                 valid;
        riscv_pkg::alu_op_e   alu_op;
        riscv_pkg::word_t     op_a;
        riscv_pkg::word_t     op_b;
        riscv_pkg::word_t     store_data;
        logic                 rf_we;
        riscv_pkg::reg_addr_t rf_waddr;
        logic                 memop_rd;
        logic                 memop_wr;
        logic                 is_branch;
        logic                 branch_ne;
        logic                 is_jal;
        addr_t                br_target;
    } core_pipeline_t;

    typedef struct packed {
        logic                 we;
        riscv_pkg::reg_addr_t waddr;
        riscv_pkg::word_t     data;
    } rf_wdata_t;

    // Stage side of the arbiter port
    typedef struct packed {
        logic             rd;
        logic             wr;
        addr_t            addr;
        riscv_pkg::word_t data;
    } mem_req_t;

    typedef struct packed {
        logic             rdy;
        riscv_pkg::word_t data;
    } mem_rsp_t;

endpackage : segre_pkg

// ==== riscv_pkg.sv ====
package riscv_pkg;

    // Architectural widths
    localparam int unsigned WORD_W     = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 32;
    localparam int unsigned OPCODE_W   = 7;
    localparam int unsigned FUNCT3_W   = 3;
    localparam int unsigned FUNCT7_W   = 7;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        PASS_B
    } alu_op_e;

    // funct3 encodings
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;
    localparam logic [FUNCT3_W-1:0] F3_WORD    = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_BEQ     = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE     = 3'b001;

    // funct7 selecting SUB over ADD
    localparam logic [FUNCT7_W-1:0] F7_SUB = 7'b0100000;

endpackage : riscv_pkg
